/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_platform_ctrl
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/domain_ctrl.sv */
// Peripheral domain controller
`timescale 1ns/1ns
`default_nettype none

`include "pctrl_consts.svh"

module domain_ctrl
  import pctrl_pkg::*;
(
  input  logic     sys_fclk,
  input  logic     rst,
  input  div_sel_t div_sel,
  input  logic     gate_en,
  input  logic     sys_rst_en,
  input  logic     rst_req,
  input  logic     sys_rst_req,
  output logic     domain_clken,
  output logic     domain_rst_n,
  output logic     rst_ack
);

  localparam int HOLD_W = $clog2(`PCTRL_RESET_HOLD + 1);
  localparam int CNT_W  = 2 ** `PCTRL_DIV_W - 1;
  localparam logic [HOLD_W-1:0] HOLD_INIT = HOLD_W'(`PCTRL_RESET_HOLD - 1);

  logic              trigger;
  logic              release_now;
  logic              ack_arm;
  logic [HOLD_W-1:0] hold_cnt;
  div_sel_t          div_sel_q;
  logic [CNT_W-1:0]  div_cnt;
  logic [CNT_W-1:0]  div_mask;

  // ------------------------------
  // Reset sequencer
  // ------------------------------

  assign trigger     = rst_req | (sys_rst_req & sys_rst_en);
  assign release_now = ~domain_rst_n & (hold_cnt == '0) & ~trigger;

  always_ff @(posedge sys_fclk) begin
    if (rst) begin
      hold_cnt     <= HOLD_INIT;
      domain_rst_n <= 1'b0;
      ack_arm      <= 1'b0;
      rst_ack      <= 1'b0;
    end else begin
      // Only requested resets are acknowledged
      rst_ack <= release_now & ack_arm;
      if (trigger) begin
        hold_cnt     <= HOLD_INIT;
        domain_rst_n <= 1'b0;
        ack_arm      <= 1'b1;
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end else begin
        domain_rst_n <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Clock enable divider
  // ------------------------------

  always_ff @(posedge sys_fclk) begin
    if (rst) begin
      div_sel_q <= '0;
      div_cnt   <= '0;
    end else begin
      div_sel_q <= div_sel;
      // Restart so the first pulse follows a rate change
      if (div_sel != div_sel_q) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign div_mask     = ~({CNT_W{1'b1}} << div_sel_q);
  assign domain_clken = domain_rst_n & gate_en & ((div_cnt & div_mask) == '0);

endmodule

`default_nettype wire

/* hw/pctrl_consts.svh */
// Platform controller constants
`ifndef PCTRL_CONSTS_SVH
`define PCTRL_CONSTS_SVH

// Domain setup
`define PCTRL_N_DOMAINS      5
`define PCTRL_RESET_HOLD     4
`define PCTRL_DIV_W          3
`define PCTRL_ADDR_W         8

// Register offsets
`define PCTRL_OFS_DOMAIN     8'h00
`define PCTRL_DOMAIN_STRIDE  4
`define PCTRL_OFS_RST_REQ    8'h20
`define PCTRL_OFS_RST_ACK    8'h24
`define PCTRL_OFS_SYS_CTRL   8'h28

// Domain control field positions
`define PCTRL_FLD_DIV        0
`define PCTRL_FLD_GATE       4
`define PCTRL_FLD_SYSRST     5

// System control fields
`define PCTRL_FLD_LOCKUP     0

`endif

/* hw/pctrl_pkg.sv */
// Platform controller types
`default_nettype none

`include "pctrl_consts.svh"

package pctrl_pkg;

  // ------------------------------
  // Per-domain vectors
  // ------------------------------

  // One bit per peripheral domain
  typedef logic [`PCTRL_N_DOMAINS-1:0] domain_mask_t;

  // Enable rate is sys_fclk / 2**value
  typedef logic [`PCTRL_DIV_W-1:0] div_sel_t;

  typedef div_sel_t [`PCTRL_N_DOMAINS-1:0] div_sel_arr_t;

  // ------------------------------
  // Bus
  // ------------------------------

  typedef logic [`PCTRL_ADDR_W-1:0] haddr_t;

endpackage

`default_nettype wire

/* hw/pctrl_regs.sv */
// Platform control registers
`timescale 1ns/1ns
`default_nettype none

`include "pctrl_consts.svh"

module pctrl_regs
  import pctrl_pkg::*;
(
  input  logic         sys_fclk,
  input  logic         rst,

  // AHB-lite slave
  input  logic         hsel,
  input  haddr_t       haddr,
  input  logic [1:0]   htrans,
  input  logic         hwrite,
  input  logic [31:0]  hwdata,
  input  logic         hreadymux,
  output logic [31:0]  hrdata,

  // System reset sources
  input  logic         sysresetreq,
  input  logic         wdog_reset_req,
  input  logic         lockup,

  // Domain controls
  output div_sel_arr_t div_sel,
  output domain_mask_t gate_en,
  output domain_mask_t sys_rst_en,
  output domain_mask_t rst_req,
  output logic         sys_rst_req,

  // Reset acknowledge status
  input  domain_mask_t ack_status,
  output domain_mask_t ack_clr
);

  haddr_t       addr_q;
  logic         wr_q;
  logic         lockup_rst_en;
  domain_mask_t wr_domain;
  logic         wr_rst_req;
  logic         wr_rst_ack;
  logic         wr_sys_ctrl;

  function automatic haddr_t domain_ofs(int idx);
    return haddr_t'(`PCTRL_OFS_DOMAIN + `PCTRL_DOMAIN_STRIDE * idx);
  endfunction

  // ------------------------------
  // Address phase
  // ------------------------------

  always_ff @(posedge sys_fclk) begin
    if (rst) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= hsel & htrans[1] & hreadymux & hwrite;
    end
  end

  // Held for the data phase of reads and writes
  always_ff @(posedge sys_fclk) begin
    if (hsel && htrans[1] && hreadymux) begin
      addr_q <= haddr;
    end
  end

  // Write decode
  always_comb begin
    for (int i = 0; i < `PCTRL_N_DOMAINS; i++) begin
      wr_domain[i] = wr_q && (addr_q == domain_ofs(i));
    end
  end

  assign wr_rst_req  = wr_q && (addr_q == `PCTRL_OFS_RST_REQ);
  assign wr_rst_ack  = wr_q && (addr_q == `PCTRL_OFS_RST_ACK);
  assign wr_sys_ctrl = wr_q && (addr_q == `PCTRL_OFS_SYS_CTRL);

  // ------------------------------
  // Control registers
  // ------------------------------

  always_ff @(posedge sys_fclk) begin
    if (rst) begin
      div_sel       <= '0;
      gate_en       <= '1;
      sys_rst_en    <= '1;
      lockup_rst_en <= 1'b0;
    end else begin
      for (int i = 0; i < `PCTRL_N_DOMAINS; i++) begin
        if (wr_domain[i]) begin
          div_sel[i]    <= hwdata[`PCTRL_FLD_DIV +: `PCTRL_DIV_W];
          gate_en[i]    <= hwdata[`PCTRL_FLD_GATE];
          sys_rst_en[i] <= hwdata[`PCTRL_FLD_SYSRST];
        end
      end
      if (wr_sys_ctrl) begin
        lockup_rst_en <= hwdata[`PCTRL_FLD_LOCKUP];
      end
    end
  end

  // Request pulses and combined system reset request
  always_ff @(posedge sys_fclk) begin
    if (rst) begin
      rst_req     <= '0;
      sys_rst_req <= 1'b0;
    end else begin
      rst_req     <= wr_rst_req ? hwdata[`PCTRL_N_DOMAINS-1:0] : '0;
      sys_rst_req <= sysresetreq | wdog_reset_req | (lockup & lockup_rst_en);
    end
  end

  // W1C strobe during the data phase
  assign ack_clr = wr_rst_ack ? hwdata[`PCTRL_N_DOMAINS-1:0] : '0;

  // ------------------------------
  // Read data
  // ------------------------------

  always_comb begin
    hrdata = '0;
    for (int i = 0; i < `PCTRL_N_DOMAINS; i++) begin
      if (addr_q == domain_ofs(i)) begin
        hrdata[`PCTRL_FLD_DIV +: `PCTRL_DIV_W] = div_sel[i];
        hrdata[`PCTRL_FLD_GATE]                = gate_en[i];
        hrdata[`PCTRL_FLD_SYSRST]              = sys_rst_en[i];
      end
    end
    if (addr_q == `PCTRL_OFS_RST_ACK) begin
      hrdata[`PCTRL_N_DOMAINS-1:0] = ack_status;
    end
    if (addr_q == `PCTRL_OFS_SYS_CTRL) begin
      hrdata[`PCTRL_FLD_LOCKUP] = lockup_rst_en;
    end
  end

endmodule

`default_nettype wire

/* hw/platform_ctrl.sv */
// Platform controller top level
`timescale 1ns/1ns
`default_nettype none

`include "pctrl_consts.svh"

module platform_ctrl
  import pctrl_pkg::*;
(
  input  logic         sys_fclk,
  input  logic         rst,

  // AHB-lite slave
  input  logic         hsel,
  input  haddr_t       haddr,
  input  logic [1:0]   htrans,
  input  logic         hwrite,
  input  logic [31:0]  hwdata,
  input  logic         hreadymux,
  output logic [31:0]  hrdata,

  // System reset sources
  input  logic         sysresetreq,
  input  logic         wdog_reset_req,
  input  logic         lockup,

  // Domain outputs
  output domain_mask_t domain_clken,
  output domain_mask_t domain_rst_n
);

  div_sel_arr_t div_sel;
  domain_mask_t gate_en;
  domain_mask_t sys_rst_en;
  domain_mask_t rst_req;
  domain_mask_t rst_ack;
  domain_mask_t ack_clr;
  domain_mask_t ack_status;
  logic         sys_rst_req;

  // ------------------------------
  // Register block
  // ------------------------------

  pctrl_regs u_pctrl_regs (
    .sys_fclk       (sys_fclk),
    .rst            (rst),
    .hsel           (hsel),
    .haddr          (haddr),
    .htrans         (htrans),
    .hwrite         (hwrite),
    .hwdata         (hwdata),
    .hreadymux      (hreadymux),
    .hrdata         (hrdata),
    .sysresetreq    (sysresetreq),
    .wdog_reset_req (wdog_reset_req),
    .lockup         (lockup),
    .div_sel        (div_sel),
    .gate_en        (gate_en),
    .sys_rst_en     (sys_rst_en),
    .rst_req        (rst_req),
    .sys_rst_req    (sys_rst_req),
    .ack_status     (ack_status),
    .ack_clr        (ack_clr)
  );

  // ------------------------------
  // Domains
  // ------------------------------

  // Index order is timer0, timer1, uart0, uart1, watchdog
  for (genvar i = 0; i < `PCTRL_N_DOMAINS; i++) begin : g_domain
    domain_ctrl u_domain_ctrl (
      .sys_fclk     (sys_fclk),
      .rst          (rst),
      .div_sel      (div_sel[i]),
      .gate_en      (gate_en[i]),
      .sys_rst_en   (sys_rst_en[i]),
      .rst_req      (rst_req[i]),
      .sys_rst_req  (sys_rst_req),
      .domain_clken (domain_clken[i]),
      .domain_rst_n (domain_rst_n[i]),
      .rst_ack      (rst_ack[i])
    );
  end

  reset_status u_reset_status (
    .sys_fclk   (sys_fclk),
    .rst        (rst),
    .rst_ack    (rst_ack),
    .ack_clr    (ack_clr),
    .ack_status (ack_status)
  );

endmodule

`default_nettype wire

/* hw/reset_status.sv */
// Reset acknowledge status
`timescale 1ns/1ns
`default_nettype none

module reset_status
  import pctrl_pkg::*;
(
  input  logic         sys_fclk,
  input  logic         rst,
  input  domain_mask_t rst_ack,
  input  domain_mask_t ack_clr,
  output domain_mask_t ack_status
);

  // ------------------------------
  // Sticky bits
  // ------------------------------

  always_ff @(posedge sys_fclk) begin
    if (rst) begin
      ack_status <= '0;
    end else begin
      // New ack beats a clear in the same cycle
      ack_status <= (ack_status & ~ack_clr) | rst_ack;
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/pctrl_pkg.sv
hw/pctrl_regs.sv
hw/domain_ctrl.sv
hw/reset_status.sv
hw/platform_ctrl.sv
tests/tb_platform_ctrl.sv

/* tests/tb_platform_ctrl.sv */
// Platform controller testbench
`timescale 1ns/1ns
`default_nettype none

`include "pctrl_consts.svh"

module tb_platform_ctrl
  import pctrl_pkg::*;
();

  localparam int N          = `PCTRL_N_DOMAINS;
  localparam int HOLD       = `PCTRL_RESET_HOLD;
  localparam int WINDOW     = 64;
  localparam int MAX_CYCLES = 4000;

  logic         sys_fclk;
  logic         rst;
  logic         hsel;
  haddr_t       haddr;
  logic [1:0]   htrans;
  logic         hwrite;
  logic [31:0]  hwdata;
  logic         hreadymux;
  logic [31:0]  hrdata;
  logic         sysresetreq;
  logic         wdog_reset_req;
  logic         lockup;
  domain_mask_t domain_clken;
  domain_mask_t domain_rst_n;

  // Register map model
  div_sel_t     m_div [N];
  domain_mask_t m_gate;
  domain_mask_t m_sysrst;
  domain_mask_t m_ack;
  logic         m_lockup;

  int low_cnt [N];
  int low_start [N];
  int rel_cnt [N];
  int rel_snap [N];
  int cyc = 0;
  int err_cnt = 0;
  int last_data_edge = 0;
  int tests_run = 0;
  int tests_ok = 0;

  platform_ctrl dut_i (
    .sys_fclk       (sys_fclk),
    .rst            (rst),
    .hsel           (hsel),
    .haddr          (haddr),
    .htrans         (htrans),
    .hwrite         (hwrite),
    .hwdata         (hwdata),
    .hreadymux      (hreadymux),
    .hrdata         (hrdata),
    .sysresetreq    (sysresetreq),
    .wdog_reset_req (wdog_reset_req),
    .lockup         (lockup),
    .domain_clken   (domain_clken),
    .domain_rst_n   (domain_rst_n)
  );

  initial sys_fclk = 1'b0;
  always #2 sys_fclk = ~sys_fclk;

  always @(posedge sys_fclk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------
  // Domain reset hold checker
  // ------------------------------

  always @(negedge sys_fclk) begin
    for (int d = 0; d < N; d++) begin
      if (rst) begin
        low_cnt[d] = 0;
      end else if (domain_rst_n[d] !== 1'b1) begin
        if (low_cnt[d] == 0) begin
          low_start[d] = cyc;
        end
        low_cnt[d] = low_cnt[d] + 1;
      end else if (low_cnt[d] != 0) begin
        rel_cnt[d] = rel_cnt[d] + 1;
        if (low_cnt[d] != HOLD) begin
          $display("[FAIL] %0t: domain %0d reset held %0d cycles, expected %0d",
                   $time, d, low_cnt[d], HOLD);
          err_cnt++;
        end
        low_cnt[d] = 0;
      end
    end
  end

  // ------------------------------
  // Reference functions
  // ------------------------------

  function automatic haddr_t domain_addr(input int i);
    return haddr_t'(`PCTRL_OFS_DOMAIN + `PCTRL_DOMAIN_STRIDE * i);
  endfunction

  function automatic int expected_clken(input int window, input int div);
    return window >> div;
  endfunction

  function automatic logic [31:0] read_model(input haddr_t addr);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < N; i++) begin
      if (addr == domain_addr(i)) begin
        v[`PCTRL_FLD_DIV +: `PCTRL_DIV_W] = m_div[i];
        v[`PCTRL_FLD_GATE]                = m_gate[i];
        v[`PCTRL_FLD_SYSRST]              = m_sysrst[i];
      end
    end
    if (addr == `PCTRL_OFS_RST_ACK) begin
      v[N-1:0] = m_ack;
    end
    if (addr == `PCTRL_OFS_SYS_CTRL) begin
      v[0] = m_lockup;
    end
    return v;
  endfunction

  // ------------------------------
  // Bus and stimulus tasks
  // ------------------------------

  task automatic write_reg(input haddr_t addr, input logic [31:0] data);
    @(posedge sys_fclk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;
    hwrite <= 1'b1;
    @(posedge sys_fclk);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwrite <= 1'b0;
    hwdata <= data;
    // Edge that opened the data phase
    @(negedge sys_fclk);
    last_data_edge = cyc;
  endtask

  task automatic read_reg(input haddr_t addr, output logic [31:0] data);
    @(posedge sys_fclk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;
    hwrite <= 1'b0;
    @(posedge sys_fclk);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    @(negedge sys_fclk);
    data = hrdata;
  endtask

  task automatic compare_read(input haddr_t addr);
    logic [31:0] rd;
    logic [31:0] want;
    read_reg(addr, rd);
    want = read_model(addr);
    if (rd !== want) begin
      $display("[FAIL] %0t: read of 0x%02h gave 0x%08h, expected 0x%08h",
               $time, addr, rd, want);
      err_cnt++;
    end
  endtask

  task automatic set_domain(input int d, input div_sel_t div, input logic gate,
                            input logic sysrst);
    logic [31:0] w;
    m_div[d]    = div;
    m_gate[d]   = gate;
    m_sysrst[d] = sysrst;
    w = '0;
    w[`PCTRL_FLD_DIV +: `PCTRL_DIV_W] = div;
    w[`PCTRL_FLD_GATE]                = gate;
    w[`PCTRL_FLD_SYSRST]              = sysrst;
    write_reg(domain_addr(d), w);
  endtask

  task automatic pulse_source(input int src);
    @(posedge sys_fclk);
    case (src)
      0: sysresetreq <= 1'b1;
      1: wdog_reset_req <= 1'b1;
      default: lockup <= 1'b1;
    endcase
    @(posedge sys_fclk);
    sysresetreq    <= 1'b0;
    wdog_reset_req <= 1'b0;
    lockup         <= 1'b0;
  endtask

  // Returns one edge after every domain is out of reset
  task automatic wait_release();
    repeat (2) @(negedge sys_fclk);
    while ((&domain_rst_n) !== 1'b1) begin
      @(negedge sys_fclk);
    end
    @(posedge sys_fclk);
  endtask

  task automatic count_clken(input int d, output int cnt);
    cnt = 0;
    repeat (3) @(negedge sys_fclk);
    repeat (WINDOW) begin
      @(negedge sys_fclk);
      if (domain_clken[d] === 1'b1) begin
        cnt++;
      end
    end
  endtask

  task automatic check_resets(input domain_mask_t mask, input string what);
    int delta;
    for (int d = 0; d < N; d++) begin
      delta = rel_cnt[d] - rel_snap[d];
      if (delta != int'(mask[d])) begin
        $display("[FAIL] %0t: %s, domain %0d saw %0d resets, expected %0d",
                 $time, what, d, delta, mask[d]);
        err_cnt++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (err_cnt == err_before) begin
      tests_ok++;
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    domain_mask_t mask;
    int d;
    int s;
    int cnt;
    int want_cnt;
    int e0;
    void'($urandom(1));
    rst            = 1'b1;
    hsel           = 1'b0;
    haddr          = '0;
    htrans         = 2'b00;
    hwrite         = 1'b0;
    hwdata         = '0;
    hreadymux      = 1'b1;
    sysresetreq    = 1'b0;
    wdog_reset_req = 1'b0;
    lockup         = 1'b0;
    m_div    = '{default: '0};
    m_gate   = '1;
    m_sysrst = '1;
    m_ack    = '0;
    m_lockup = 1'b0;

    // Reset release and reset values
    repeat (2) @(posedge sys_fclk);
    rst <= 1'b0;
    e0 = err_cnt;
    wait_release();
    for (d = 0; d < N; d++) begin
      if (rel_cnt[d] != 1) begin
        $display("[FAIL] %0t: domain %0d released %0d times after reset, expected 1",
                 $time, d, rel_cnt[d]);
        err_cnt++;
      end
      compare_read(domain_addr(d));
    end
    compare_read(`PCTRL_OFS_RST_ACK);
    compare_read(8'h30);
    finish_test("reset", e0);

    // Divided clock enables and gating
    e0 = err_cnt;
    repeat (6) begin
      d = $urandom % N;
      s = $urandom % (1 << `PCTRL_DIV_W);
      set_domain(d, div_sel_t'(s), 1'b1, m_sysrst[d]);
      compare_read(domain_addr(d));
      count_clken(d, cnt);
      want_cnt = expected_clken(WINDOW, s);
      if (cnt > want_cnt + 1 || cnt < want_cnt - 1) begin
        $display("[FAIL] %0t: domain %0d div %0d gave %0d enables, expected %0d",
                 $time, d, s, cnt, want_cnt);
        err_cnt++;
      end
    end
    // Full rate, so an ungated domain would pulse every cycle
    set_domain(d, '0, 1'b0, m_sysrst[d]);
    count_clken(d, cnt);
    if (cnt != 0) begin
      $display("[FAIL] %0t: gated domain %0d gave %0d enables", $time, d, cnt);
      err_cnt++;
    end
    set_domain(d, '0, 1'b1, m_sysrst[d]);
    finish_test("clock enable", e0);

    // Software reset requests one-hot then multi-bit
    e0 = err_cnt;
    for (int t = 0; t < 4; t++) begin
      if (t < 2) begin
        mask = domain_mask_t'(1 << ($urandom % N));
      end else begin
        mask = domain_mask_t'($urandom % 31 + 1);
      end
      rel_snap = rel_cnt;
      write_reg(`PCTRL_OFS_RST_REQ, 32'(mask));
      wait_release();
      check_resets(mask, "RST_REQ");
      for (d = 0; d < N; d++) begin
        if (mask[d] && low_start[d] != last_data_edge + 2) begin
          $display("[FAIL] %0t: domain %0d reset started at cycle %0d, expected %0d",
                   $time, d, low_start[d], last_data_edge + 2);
          err_cnt++;
        end
      end
      m_ack = m_ack | mask;
      compare_read(`PCTRL_OFS_RST_ACK);
    end
    compare_read(`PCTRL_OFS_RST_REQ);
    finish_test("reset request", e0);

    // Write-one-to-clear of the sticky acks
    e0 = err_cnt;
    mask = '1;
    rel_snap = rel_cnt;
    write_reg(`PCTRL_OFS_RST_REQ, 32'(mask));
    wait_release();
    check_resets(mask, "RST_REQ all");
    m_ack = '1;
    compare_read(`PCTRL_OFS_RST_ACK);
    repeat (3) begin
      mask = domain_mask_t'($urandom);
      write_reg(`PCTRL_OFS_RST_ACK, 32'(mask));
      m_ack = m_ack & ~mask;
      compare_read(`PCTRL_OFS_RST_ACK);
    end
    finish_test("ack clear", e0);

    // System reset sources with lockup last
    e0 = err_cnt;
    // At least one domain enabled and at least one left out
    mask = domain_mask_t'($urandom % 30 + 1);
    for (d = 0; d < N; d++) begin
      set_domain(d, m_div[d], m_gate[d], mask[d]);
    end
    for (s = 0; s < 4; s++) begin
      if (s == 3) begin
        write_reg(`PCTRL_OFS_SYS_CTRL, 32'h1);
        m_lockup = 1'b1;
        compare_read(`PCTRL_OFS_SYS_CTRL);
      end
      rel_snap = rel_cnt;
      pulse_source((s == 3) ? 2 : s);
      if (s == 2) begin
        repeat (HOLD + 8) @(posedge sys_fclk);
        check_resets('0, "lockup disabled");
      end else begin
        wait_release();
        check_resets(mask, "system reset");
        m_ack = m_ack | mask;
      end
    end
    compare_read(`PCTRL_OFS_RST_ACK);
    finish_test("system reset", e0);

    $display("Tests passed: %0d of %0d, errors: %0d", tests_ok, tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
